// ==== src/spad_consts.svh ====
`ifndef SPAD_CONSTS_SVH
`define SPAD_CONSTS_SVH

// word geometry of the scratchpad
`define SPAD_DATAW 32
`define SPAD_SIZE 256
`define SPAD_WRENW 4

// a latency of 2 turns on the RAM output register
`define SPAD_READ_LAT 2

// 1 lets a read see the word written at the same edge, 0 returns the old word
`define SPAD_WRITE_FIRST 1

// every word holds this pattern after power-up
`define SPAD_INIT_VALUE 32'h5a5a_0000

`endif

// ==== src/spad_pkg.sv ====
`include "spad_consts.svh"

package spad_pkg;

    typedef logic [$clog2(`SPAD_SIZE)-1:0] spad_addr_t;
    typedef logic [`SPAD_DATAW-1:0] spad_data_t;
    typedef logic [`SPAD_WRENW-1:0] spad_wren_t;

    // one client request where wren only matters for writes
    typedef struct packed {
        logic       write;
        spad_addr_t addr;
        spad_data_t wdata;
        spad_wren_t wren;
    } spad_req_t;

    // reads return the word, writes return zero
    typedef struct packed {
        spad_data_t rdata;
    } spad_rsp_t;

    // an operation travelling down a tag pipeline
    typedef struct packed {
        logic valid;
        logic port;
    } spad_tag_t;

endpackage

// ==== src/spad_ram.sv ====
`timescale 1ns/1ns

module spad_ram #(
    parameter int              DATAW       = 32,
    parameter int              SIZE        = 256,
    parameter int              WRENW       = 4,
    parameter bit              WRITE_FIRST = 1'b1,
    parameter bit              OUT_REG     = 1'b1,
    parameter logic [DATAW-1:0] INIT_VALUE = '0
) (
    input  logic                    clk,
    input  logic                    RADDR_RESET,
    input  logic                    we,
    input  logic [$clog2(SIZE)-1:0] waddr,
    input  logic [DATAW-1:0]        wdata,
    input  logic [WRENW-1:0]        wren,
    input  logic                    re,
    input  logic [$clog2(SIZE)-1:0] raddr,
    output logic [DATAW-1:0]        rdata
);

    localparam int LANEW = DATAW / WRENW;

    logic [DATAW-1:0] mem [SIZE];
    logic [DATAW-1:0] rd_word;

    // power-up contents
    initial begin
        for (int i = 0; i < SIZE; i++) begin
            mem[i] = INIT_VALUE;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < WRENW; i++) begin
                if (wren[i]) begin
                    mem[waddr][i*LANEW +: LANEW] <= wdata[i*LANEW +: LANEW];
                end
            end
        end
    end

    if (WRITE_FIRST) begin : g_write_first
        logic [$clog2(SIZE)-1:0] raddr_q;

        // the array is looked up after the edge, so a same-edge write is already in
        always_ff @(posedge clk) begin
            if (RADDR_RESET) begin
                raddr_q <= '0;
            end else if (re) begin
                raddr_q <= raddr;
            end
        end

        assign rd_word = mem[raddr_q];
    end else begin : g_read_first
        logic [DATAW-1:0] data_q;

        // sampled at the edge, before any write at that edge lands
        always_ff @(posedge clk) begin
            if (RADDR_RESET) begin
                data_q <= '0;
            end else if (re) begin
                data_q <= mem[raddr];
            end
        end

        assign rd_word = data_q;
    end

    if (OUT_REG) begin : g_out_reg
        logic [DATAW-1:0] out_q;

        always_ff @(posedge clk) begin
            if (RADDR_RESET) begin
                out_q <= '0;
            end else begin
                out_q <= rd_word;
            end
        end

        assign rdata = out_q;
    end else begin : g_no_out_reg
        assign rdata = rd_word;
    end

endmodule

// ==== src/spad_port.sv ====
`timescale 1ns/1ns

module spad_port (
    input  logic                clk,
    input  logic                RADDR_RESET,
    input  logic                req,
    input  spad_pkg::spad_req_t req_data,
    input  logic                grant,
    input  logic                done,
    input  spad_pkg::spad_rsp_t done_rsp,
    output logic                ack,
    output spad_pkg::spad_rsp_t rsp,
    output logic                pend,
    output spad_pkg::spad_req_t pend_req
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PEND,
        S_WAIT
    } state_t;

    state_t state;

    // the request waits in S_PEND for the issue stage to pick it
    assign pend = (state == S_PEND);

    always_ff @(posedge clk) begin
        if (RADDR_RESET) begin
            state <= S_IDLE;
            ack   <= 1'b0;
            rsp   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_PEND;
                    end
                end
                S_PEND: begin
                    if (grant) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // done comes once per grant, then ack stays up until req drops
                    if (done) begin
                        rsp <= done_rsp;
                        ack <= 1'b1;
                    end
                    if (ack && !req) begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // capture the request on the edge that first sees req from idle
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            pend_req <= req_data;
        end
    end

endmodule

// ==== src/spad_issue.sv ====
`timescale 1ns/1ns

`include "spad_consts.svh"

module spad_issue (
    input  logic                      clk,
    input  logic                      RADDR_RESET,
    input  logic [1:0]                pend,
    input  spad_pkg::spad_req_t [1:0] pend_req,
    input  spad_pkg::spad_data_t      ram_rdata,
    output logic [1:0]                grant,
    output logic                      we,
    output spad_pkg::spad_addr_t      waddr,
    output spad_pkg::spad_data_t      wdata,
    output spad_pkg::spad_wren_t      wren,
    output logic                      re,
    output spad_pkg::spad_addr_t      raddr,
    output logic [1:0]                done,
    output spad_pkg::spad_rsp_t [1:0] done_rsp
);

    import spad_pkg::*;

    localparam int LAT = `SPAD_READ_LAT;

    logic [1:0] wr_pend;
    logic [1:0] rd_pend;
    logic [1:0] wr_gnt;
    logic [1:0] rd_gnt;
    logic       wr_prio;
    logic       rd_prio;
    logic       wr_sel;
    logic       rd_sel;

    spad_tag_t [LAT-1:0] wr_tags;
    spad_tag_t [LAT-1:0] rd_tags;
    spad_tag_t           wr_out;
    spad_tag_t           rd_out;

    // picks the port to serve; a tie goes to the port holding priority
    function automatic logic rr_pick(input logic [1:0] req_v, input logic prio);
        if (req_v == 2'b11) begin
            return prio;
        end
        return req_v[1];
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_pend[i] = pend[i] & pend_req[i].write;
            rd_pend[i] = pend[i] & ~pend_req[i].write;
        end
    end

    assign wr_sel = rr_pick(wr_pend, wr_prio);
    assign rd_sel = rr_pick(rd_pend, rd_prio);

    assign wr_gnt = (|wr_pend) ? (2'b01 << wr_sel) : 2'b00;
    assign rd_gnt = (|rd_pend) ? (2'b01 << rd_sel) : 2'b00;
    assign grant  = wr_gnt | rd_gnt;

    // one write and one read can go to the RAM in the same cycle
    assign we    = |wr_pend;
    assign waddr = pend_req[wr_sel].addr;
    assign wdata = pend_req[wr_sel].wdata;
    assign wren  = pend_req[wr_sel].wren;
    assign re    = |rd_pend;
    assign raddr = pend_req[rd_sel].addr;

    // priority only moves when both ports competed for the same kind
    always_ff @(posedge clk) begin
        if (RADDR_RESET) begin
            wr_prio <= 1'b0;
            rd_prio <= 1'b0;
        end else begin
            if (&wr_pend) begin
                wr_prio <= ~wr_prio;
            end
            if (&rd_pend) begin
                rd_prio <= ~rd_prio;
            end
        end
    end

    // tags travel alongside the RAM access and pop out with the read data
    always_ff @(posedge clk) begin
        if (RADDR_RESET) begin
            wr_tags <= '0;
            rd_tags <= '0;
        end else begin
            wr_tags[0] <= '{valid: we, port: wr_sel};
            rd_tags[0] <= '{valid: re, port: rd_sel};
            for (int s = 1; s < LAT; s++) begin
                wr_tags[s] <= wr_tags[s-1];
                rd_tags[s] <= rd_tags[s-1];
            end
        end
    end

    assign wr_out = wr_tags[LAT-1];
    assign rd_out = rd_tags[LAT-1];

    // each port has at most one operation in flight, so at most one tag matches it
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            done[i] = (wr_out.valid && wr_out.port == 1'(i))
                   || (rd_out.valid && rd_out.port == 1'(i));
            if (rd_out.valid && rd_out.port == 1'(i)) begin
                done_rsp[i].rdata = ram_rdata;
            end else begin
                done_rsp[i].rdata = '0;
            end
        end
    end

endmodule

// ==== src/spad_top.sv ====
`timescale 1ns/1ns

`include "spad_consts.svh"

module spad_top (
    input  logic                clk,
    input  logic                RADDR_RESET,
    input  logic                req0,
    input  spad_pkg::spad_req_t req_data0,
    input  logic                req1,
    input  spad_pkg::spad_req_t req_data1,
    output logic                ack0,
    output spad_pkg::spad_rsp_t rsp0,
    output logic                ack1,
    output spad_pkg::spad_rsp_t rsp1
);

    import spad_pkg::*;

    logic [1:0]      pend;
    logic [1:0]      grant;
    logic [1:0]      done;
    spad_req_t [1:0] pend_req;
    spad_rsp_t [1:0] done_rsp;

    logic       we;
    logic       re;
    spad_addr_t waddr;
    spad_addr_t raddr;
    spad_data_t wdata;
    spad_data_t ram_rdata;
    spad_wren_t wren;

    spad_port port0_i (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .req         (req0),
        .req_data    (req_data0),
        .grant       (grant[0]),
        .done        (done[0]),
        .done_rsp    (done_rsp[0]),
        .ack         (ack0),
        .rsp         (rsp0),
        .pend        (pend[0]),
        .pend_req    (pend_req[0])
    );

    spad_port port1_i (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .req         (req1),
        .req_data    (req_data1),
        .grant       (grant[1]),
        .done        (done[1]),
        .done_rsp    (done_rsp[1]),
        .ack         (ack1),
        .rsp         (rsp1),
        .pend        (pend[1]),
        .pend_req    (pend_req[1])
    );

    spad_issue issue_i (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .pend        (pend),
        .pend_req    (pend_req),
        .ram_rdata   (ram_rdata),
        .grant       (grant),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .wren        (wren),
        .re          (re),
        .raddr       (raddr),
        .done        (done),
        .done_rsp    (done_rsp)
    );

    // a read latency of 2 means the output register is in
    spad_ram #(
        .DATAW       (`SPAD_DATAW),
        .SIZE        (`SPAD_SIZE),
        .WRENW       (`SPAD_WRENW),
        .WRITE_FIRST (`SPAD_WRITE_FIRST),
        .OUT_REG     (`SPAD_READ_LAT == 2),
        .INIT_VALUE  (`SPAD_INIT_VALUE)
    ) ram_i (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .wren        (wren),
        .re          (re),
        .raddr       (raddr),
        .rdata       (ram_rdata)
    );

endmodule

// ==== dv/spad_tb.sv ====
`timescale 1ns/1ns

`include "spad_consts.svh"

module spad_tb;

    import spad_pkg::*;

    // edges from the one that first samples req to the one that first samples ack
    localparam int ACK_EDGES = `SPAD_READ_LAT + 2;
    localparam int TIMEOUT   = 40;
    localparam int LANEW     = `SPAD_DATAW / `SPAD_WRENW;
    localparam int N_RANDOM  = 100;

    logic      clk;
    logic      RADDR_RESET;
    logic      req0;
    logic      req1;
    spad_req_t req_data0;
    spad_req_t req_data1;
    logic      ack0;
    logic      ack1;
    spad_rsp_t rsp0;
    spad_rsp_t rsp1;

    spad_data_t  model [`SPAD_SIZE];
    logic [31:0] rng_state;

    // each port claims its word here so the two ports never race on one address
    logic       busy      [2];
    logic       busy_wr   [2];
    spad_addr_t busy_addr [2];

    spad_top dut_i (
        .clk         (clk),
        .RADDR_RESET (RADDR_RESET),
        .req0        (req0),
        .req_data0   (req_data0),
        .req1        (req1),
        .req_data1   (req_data1),
        .ack0        (ack0),
        .rsp0        (rsp0),
        .ack1        (ack1),
        .rsp1        (rsp1)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input spad_data_t got, input spad_data_t exp);
        assert (got === exp) else begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    acks_low_after_reset: assert property (@(posedge clk) RADDR_RESET |=> !ack0 && !ack1)
        else begin
            $display("an ack was high right after reset at %0t", $time);
            stop_run();
        end

    ack0_needs_req: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (!ack0 && !req0) |=> !ack0) else begin
            $display("ack0 rose with no req0 at %0t", $time);
            stop_run();
        end

    ack1_needs_req: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (!ack1 && !req1) |=> !ack1) else begin
            $display("ack1 rose with no req1 at %0t", $time);
            stop_run();
        end

    // a held req keeps ack up, so ack cannot pulse twice in one handshake
    ack0_holds: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (ack0 && req0) |=> ack0) else begin
            $display("ack0 dropped while req0 was still high at %0t", $time);
            stop_run();
        end

    ack1_holds: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (ack1 && req1) |=> ack1) else begin
            $display("ack1 dropped while req1 was still high at %0t", $time);
            stop_run();
        end

    ack0_falls: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (ack0 && !req0) |=> !ack0) else begin
            $display("ack0 stayed high after req0 fell at %0t", $time);
            stop_run();
        end

    ack1_falls: assert property (@(posedge clk) disable iff (RADDR_RESET)
        (ack1 && !req1) |=> !ack1) else begin
            $display("ack1 stayed high after req1 fell at %0t", $time);
            stop_run();
        end

    function automatic logic [31:0] rand32();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic spad_req_t make_req(input logic write, input spad_addr_t addr,
                                           input spad_data_t wdata, input spad_wren_t wren);
        spad_req_t d;
        d.write = write;
        d.addr  = addr;
        d.wdata = wdata;
        d.wren  = wren;
        return d;
    endfunction

    function automatic spad_data_t merge_lanes(input spad_data_t old_word,
                                               input spad_data_t wdata, input spad_wren_t wren);
        spad_data_t res;
        res = old_word;
        for (int l = 0; l < `SPAD_WRENW; l++) begin
            if (wren[l]) begin
                res[l*LANEW +: LANEW] = wdata[l*LANEW +: LANEW];
            end
        end
        return res;
    endfunction

    function automatic logic ack_of(input int p);
        return (p == 0) ? ack0 : ack1;
    endfunction

    function automatic spad_rsp_t rsp_of(input int p);
        return (p == 0) ? rsp0 : rsp1;
    endfunction

    task automatic set_req(input int p, input logic v, input spad_req_t d);
        if (p == 0) begin
            req0      <= v;
            req_data0 <= d;
        end else begin
            req1      <= v;
            req_data1 <= d;
        end
    endtask

    // runs one full four-phase handshake and samples outputs on the falling edge
    task automatic run_op(input int p, input spad_req_t d, output spad_rsp_t r,
                          output int rise_edges);
        int k;
        @(posedge clk);
        set_req(p, 1'b1, d);
        @(negedge clk);
        k = 1;
        while (!ack_of(p)) begin
            if (k >= TIMEOUT) begin
                $display("port %0d gave no ack within %0d cycles", p, TIMEOUT);
                stop_run();
            end
            @(negedge clk);
            k++;
        end
        // falling edge k lies just before edge k-1 counted from the edge that samples req
        rise_edges = k - 1;
        r = rsp_of(p);
        @(posedge clk);
        set_req(p, 1'b0, d);
        @(negedge clk);
        k = 1;
        while (ack_of(p)) begin
            if (k >= TIMEOUT) begin
                $display("port %0d kept ack high for %0d cycles after req fell", p, TIMEOUT);
                stop_run();
            end
            @(negedge clk);
            k++;
        end
        check_count($sformatf("ack%0d fall edges", p), k - 1, 1);
    endtask

    task automatic finish_op(input int p, input spad_req_t d, input spad_rsp_t r);
        if (d.write) begin
            check_value($sformatf("rsp%0d", p), r.rdata, '0);
            model[d.addr] = merge_lanes(model[d.addr], d.wdata, d.wren);
        end else begin
            check_value($sformatf("rsp%0d", p), r.rdata, model[d.addr]);
        end
    endtask

    task automatic single_op(input int p, input spad_req_t d);
        spad_rsp_t r;
        int        e;
        run_op(p, d, r, e);
        check_count($sformatf("ack%0d rise edges", p), e, ACK_EDGES);
        finish_op(p, d, r);
    endtask

    task automatic random_traffic(input int p, input int n);
        spad_req_t   d;
        spad_rsp_t   r;
        int          e;
        logic [31:0] x;
        spad_addr_t  a;
        for (int i = 0; i < n; i++) begin
            x = rand32();
            a = spad_addr_t'(x[27:24]);
            // step off the other port's word when either side writes it
            if (busy[1-p] && busy_addr[1-p] == a && (busy_wr[1-p] || x[31])) begin
                a = a + 8'd1;
            end
            d = make_req(x[31], a, rand32(), x[3:0]);
            busy_addr[p] = a;
            busy_wr[p]   = d.write;
            busy[p]      = 1'b1;
            run_op(p, d, r, e);
            finish_op(p, d, r);
            busy[p] = 1'b0;
            repeat (x[9:8]) @(posedge clk);
        end
    endtask

    initial begin
        spad_req_t  d0;
        spad_req_t  d1;
        spad_rsp_t  r0;
        spad_rsp_t  r1;
        int         e0;
        int         e1;
        spad_addr_t a;
        spad_data_t wd;
        spad_data_t exp_rd;
        spad_wren_t masks [5];

        clk         = 1'b0;
        RADDR_RESET = 1'b1;
        req0        = 1'b0;
        req1        = 1'b0;
        req_data0   = '0;
        req_data1   = '0;
        rng_state   = 32'he1b50ab5;
        for (int i = 0; i < `SPAD_SIZE; i++) begin
            model[i] = `SPAD_INIT_VALUE;
        end
        for (int p = 0; p < 2; p++) begin
            busy[p]      = 1'b0;
            busy_wr[p]   = 1'b0;
            busy_addr[p] = '0;
        end

        repeat (2) @(posedge clk);
        RADDR_RESET <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_count("ack0", int'(ack0), 0);
            check_count("ack1", int'(ack1), 0);
            check_value("rsp0", rsp0.rdata, '0);
            check_value("rsp1", rsp1.rdata, '0);
        end

        // untouched words still hold the power-up fill
        for (int i = 0; i < 8; i++) begin
            d0 = make_req(1'b0, spad_addr_t'(8'hf8 + i), '0, '0);
            single_op(i % 2, d0);
        end

        single_op(0, make_req(1'b1, 8'h40, 32'hdead_beef, 4'hf));
        single_op(0, make_req(1'b0, 8'h40, '0, '0));
        single_op(1, make_req(1'b1, 8'h41, 32'h1234_5678, 4'hf));
        single_op(1, make_req(1'b0, 8'h41, '0, '0));

        masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1011, 4'b0100};
        for (int i = 0; i < 5; i++) begin
            single_op(i % 2, make_req(1'b1, 8'h50, rand32(), masks[i]));
            single_op((i + 1) % 2, make_req(1'b0, 8'h50, '0, '0));
        end

        fork
            random_traffic(0, N_RANDOM);
            random_traffic(1, N_RANDOM);
        join

        // same-edge write and read of one word from the two ports
        a      = 8'h60;
        wd     = 32'hc0ff_ee11;
        exp_rd = (`SPAD_WRITE_FIRST != 0) ? wd : model[a];
        d0     = make_req(1'b1, a, wd, 4'hf);
        d1     = make_req(1'b0, a, '0, '0);
        fork
            run_op(0, d0, r0, e0);
            run_op(1, d1, r1, e1);
        join
        check_count("ack0 rise edges", e0, ACK_EDGES);
        check_count("ack1 rise edges", e1, e0);
        check_value("rsp0", r0.rdata, '0);
        check_value("rsp1", r1.rdata, exp_rd);
        model[a] = merge_lanes(model[a], wd, 4'hf);
        single_op(1, d1);

        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/spad_pkg.sv
src/spad_ram.sv
src/spad_port.sv
src/spad_issue.sv
src/spad_top.sv
dv/spad_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the scratchpad testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spad_tb -f list.f -o spad_sim \
    && ./obj_dir/spad_sim \
    || exit 1
